//--- Makefile
# Verilator build and run for the RV64 backend testbench.
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := rv64_backend_tb
FILELIST  := rv64_backend.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@output="$$(./$(SIM))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)

//--- rv64_backend.f
source/rv_types_pkg.sv
source/rv_ctrl_pkg.sv
source/ex_mem_if.sv
source/execute_stage.sv
source/ex_mem_reg.sv
source/memory_stage.sv
source/writeback_stage.sv
source/rv64_backend.sv
testbench/rv64_backend_tb.sv

//--- source/ex_mem_if.sv
// --------------------
// EX/MEM register outputs, shared by
// the register, memory and execute stages.
// --------------------
`default_nettype none

interface ex_mem_if
    import rv_types_pkg::*;
();

    xlen_t     alu_out;
    xlen_t     data;            // Store data after execute forwarding.
    reg_addr_t rs2_ID_EX;       // Source of the store data.
    reg_addr_t rd;
    logic      mem_to_reg;
    logic      reg_write_en;
    logic      mem_read;
    logic      mem_write;

    modport writer (
        output alu_out, data, rs2_ID_EX, rd,
        output mem_to_reg, reg_write_en, mem_read, mem_write
    );

    modport mem_reader (
        input alu_out, data, rs2_ID_EX, mem_read, mem_write
    );

    modport fwd_reader (
        input alu_out, rd, mem_to_reg, reg_write_en
    );

endinterface

`default_nettype wire

//--- source/ex_mem_reg.sv
// --------------------
// EX/MEM pipeline register.
// --------------------
`default_nettype none

module ex_mem_reg
    import rv_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_to_reg,
    input  logic      reg_write_en,
    input  logic      mem_read,
    input  logic      mem_write,
    input  xlen_t     alu_out,
    input  xlen_t     data,
    input  reg_addr_t rs2_ID_EX,
    input  reg_addr_t rd,
    ex_mem_if.writer  ex_mem
);

    // Every field is captured each cycle since the pipeline never stalls.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem.alu_out      <= '0;
            ex_mem.data         <= '0;
            ex_mem.rs2_ID_EX    <= '0;
            ex_mem.rd           <= '0;
            ex_mem.mem_to_reg   <= 1'b0;
            ex_mem.reg_write_en <= 1'b0;     // Cleared controls make a bubble.
            ex_mem.mem_read     <= 1'b0;
            ex_mem.mem_write    <= 1'b0;
        end else begin
            ex_mem.alu_out      <= alu_out;
            ex_mem.data         <= data;
            ex_mem.rs2_ID_EX    <= rs2_ID_EX;
            ex_mem.rd           <= rd;
            ex_mem.mem_to_reg   <= mem_to_reg;
            ex_mem.reg_write_en <= reg_write_en;
            ex_mem.mem_read     <= mem_read;
            ex_mem.mem_write    <= mem_write;
        end
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// --------------------
// Execute stage: operand forwarding,
// immediate select and the 64-bit ALU.
// --------------------
`default_nettype none

module execute_stage
    import rv_types_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  alu_op_t   alu_op,
    input  logic      alu_src,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  xlen_t     rs1_value,
    input  xlen_t     rs2_value,
    input  xlen_t     imm,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  xlen_t     wb_data,
    ex_mem_if.fwd_reader ex_mem,
    output xlen_t     alu_out,
    output xlen_t     store_data
);

    logic       mem_fwd_ok;
    logic       wb_fwd_ok;
    fwd_sel_t   fwd_a;
    fwd_sel_t   fwd_b;
    xlen_t      operand_a;
    xlen_t      rs2_fwd;
    xlen_t      operand_b;
    logic [5:0] shamt;

    // EX/MEM has the newer value, so it is checked first.
    function automatic fwd_sel_t pick_source(
        input reg_addr_t src,
        input logic      mem_ok,
        input reg_addr_t mem_rd,
        input logic      wb_ok,
        input reg_addr_t wb_dest
    );
        if (mem_ok && (mem_rd == src)) begin
            return fwd_ex_mem;
        end
        if (wb_ok && (wb_dest == src)) begin
            return fwd_mem_wb;
        end
        return fwd_none;
    endfunction

    function automatic xlen_t fwd_value(
        input fwd_sel_t sel,
        input xlen_t    reg_value,
        input xlen_t    mem_value,
        input xlen_t    wb_value
    );
        case (sel)
            fwd_ex_mem: return mem_value;
            fwd_mem_wb: return wb_value;
            default:    return reg_value;
        endcase
    endfunction

    // A load result is not ready in EX/MEM yet, and register 0 is never forwarded.
    assign mem_fwd_ok = ex_mem.reg_write_en && !ex_mem.mem_to_reg && (ex_mem.rd != '0);
    assign wb_fwd_ok  = wb_en && (wb_rd != '0);

    assign fwd_a = pick_source(rs1, mem_fwd_ok, ex_mem.rd, wb_fwd_ok, wb_rd);
    assign fwd_b = pick_source(rs2, mem_fwd_ok, ex_mem.rd, wb_fwd_ok, wb_rd);

    assign operand_a = fwd_value(fwd_a, rs1_value, ex_mem.alu_out, wb_data);
    assign rs2_fwd   = fwd_value(fwd_b, rs2_value, ex_mem.alu_out, wb_data);

    assign operand_b  = alu_src ? imm : rs2_fwd;
    assign store_data = rs2_fwd;               // A store always uses the register value.
    assign shamt      = operand_b[5:0];

    always_comb begin
        case (alu_op)
            alu_add:  alu_out = operand_a + operand_b;
            alu_sub:  alu_out = operand_a - operand_b;
            alu_and:  alu_out = operand_a & operand_b;
            alu_or:   alu_out = operand_a | operand_b;
            alu_xor:  alu_out = operand_a ^ operand_b;
            alu_sll:  alu_out = operand_a << shamt;
            alu_srl:  alu_out = operand_a >> shamt;
            alu_sra:  alu_out = xlen_t'($signed(operand_a) >>> shamt);
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, operand_a < operand_b};
            default:  alu_out = '0;            // Unused codes.
        endcase
    end

endmodule

`default_nettype wire

//--- source/memory_stage.sv
// --------------------
// Memory stage: 256-doubleword data memory
// with store-data forwarding from write-back.
// --------------------
`default_nettype none

module memory_stage
    import rv_types_pkg::*;
(
    input  logic          clk,
    input  logic          wb_en,
    input  reg_addr_t     wb_rd,
    input  xlen_t         wb_data,
    ex_mem_if.mem_reader  ex_mem,
    output xlen_t         load_data
);

    xlen_t      mem [mem_depth];
    mem_index_t index;
    logic       store_fwd;
    xlen_t      store_value;

    assign index = ex_mem.alu_out[mem_index_msb:mem_index_lsb];    // Doubleword aligned.

    // A load just ahead of the store has its result on the write-back port now.
    assign store_fwd   = wb_en && (wb_rd != '0) && (wb_rd == ex_mem.rs2_ID_EX);
    assign store_value = store_fwd ? wb_data : ex_mem.data;

    // The write lands on the edge that ends the store's MEM cycle.
    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            mem[index] <= store_value;
        end
    end

    // Asynchronous read, so a load finishes within its MEM cycle.
    assign load_data = ex_mem.mem_read ? mem[index] : '0;

endmodule

`default_nettype wire

//--- source/rv64_backend.sv
// --------------------
// RV64I pipeline back half: execute,
// EX/MEM, memory access and write-back.
// --------------------
`default_nettype none

module rv64_backend
    import rv_types_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  alu_op_t   alu_op,
    input  logic      alu_src,
    input  logic      mem_to_reg,
    input  logic      reg_write_en,
    input  logic      mem_read,
    input  logic      mem_write,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  xlen_t     rs1_value,
    input  xlen_t     rs2_value,
    input  xlen_t     imm,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data
);

    xlen_t alu_out_ex;
    xlen_t store_data_ex;
    xlen_t load_data_mem;

    ex_mem_if ex_mem_bus ();

    execute_stage execute_stage_inst (
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .imm        (imm),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .ex_mem     (ex_mem_bus.fwd_reader),
        .alu_out    (alu_out_ex),
        .store_data (store_data_ex)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk          (clk),
        .reset        (reset),
        .mem_to_reg   (mem_to_reg),
        .reg_write_en (reg_write_en),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .alu_out      (alu_out_ex),
        .data         (store_data_ex),
        .rs2_ID_EX    (rs2),             // Kept for store-data forwarding in MEM.
        .rd           (rd),
        .ex_mem       (ex_mem_bus.writer)
    );

    memory_stage memory_stage_inst (
        .clk       (clk),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .ex_mem    (ex_mem_bus.mem_reader),
        .load_data (load_data_mem)
    );

    writeback_stage writeback_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .reg_write_en (ex_mem_bus.reg_write_en),
        .mem_to_reg   (ex_mem_bus.mem_to_reg),
        .rd           (ex_mem_bus.rd),
        .alu_out      (ex_mem_bus.alu_out),
        .load_data    (load_data_mem),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

//--- source/rv_ctrl_pkg.sv
// --------------------
// RV64 backend control codes.
// ALU operations and forwarding selects.
// --------------------
`default_nettype none

package rv_ctrl_pkg;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_and  = 4'd2;
    localparam alu_op_t alu_or   = 4'd3;
    localparam alu_op_t alu_xor  = 4'd4;
    localparam alu_op_t alu_sll  = 4'd5;   // Shifts use the low 6 bits of operand b.
    localparam alu_op_t alu_srl  = 4'd6;
    localparam alu_op_t alu_sra  = 4'd7;
    localparam alu_op_t alu_slt  = 4'd8;   // Compares give 1 or 0.
    localparam alu_op_t alu_sltu = 4'd9;

    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t fwd_none   = 2'd0;    // Value from the register file.
    localparam fwd_sel_t fwd_ex_mem = 2'd1;    // ALU result waiting in EX/MEM.
    localparam fwd_sel_t fwd_mem_wb = 2'd2;    // Result on the write-back port.

endpackage

`default_nettype wire

//--- source/rv_types_pkg.sv
// --------------------
// RV64 backend data types.
// Word, register number and data memory sizes.
// --------------------
`default_nettype none

package rv_types_pkg;

    localparam int xlen = 64;               // Width of one data word.
    localparam int reg_addr_bits = 5;       // 32 integer registers.
    localparam int mem_index_bits = 8;

    localparam int mem_depth = 256;         // Doublewords in the data memory.

    // The doubleword index sits in address bits 10 down to 3.
    localparam int mem_index_lsb = 3;
    localparam int mem_index_msb = mem_index_lsb + mem_index_bits - 1;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [reg_addr_bits-1:0] reg_addr_t;   // Register 0 always reads zero.
    typedef logic [mem_index_bits-1:0] mem_index_t;

endpackage

`default_nettype wire

//--- source/writeback_stage.sv
// --------------------
// MEM/WB register and the
// write-back data select.
// --------------------
`default_nettype none

module writeback_stage
    import rv_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      reg_write_en,
    input  logic      mem_to_reg,
    input  reg_addr_t rd,
    input  xlen_t     alu_out,
    input  xlen_t     load_data,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data
);

    logic      reg_write_en_q;
    logic      mem_to_reg_q;
    reg_addr_t rd_q;
    xlen_t     alu_out_q;
    xlen_t     load_data_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_en_q <= 1'b0;
            mem_to_reg_q   <= 1'b0;
            rd_q           <= '0;
            alu_out_q      <= '0;
            load_data_q    <= '0;
        end else begin
            reg_write_en_q <= reg_write_en;
            mem_to_reg_q   <= mem_to_reg;
            rd_q           <= rd;
            alu_out_q      <= alu_out;
            load_data_q    <= load_data;
        end
    end

    assign wb_en   = reg_write_en_q;
    assign wb_rd   = rd_q;
    assign wb_data = mem_to_reg_q ? load_data_q : alu_out_q;    // Loads take the memory word.

endmodule

`default_nettype wire

//--- testbench/rv64_backend_tb.sv
// --------------------
// Testbench for the RV64 backend with directed
// ALU, forwarding and load/store tests.
// --------------------
`default_nettype none

module rv64_backend_tb
    import rv_types_pkg::*;
    import rv_ctrl_pkg::*;
();

    localparam int drain_limit = 20;            // Cycles allowed for results to come out.
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic      clk = 1'b0;
    logic      reset;
    alu_op_t   alu_op;
    logic      alu_src;
    logic      mem_to_reg;
    logic      reg_write_en;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     rs1_value;
    xlen_t     rs2_value;
    xlen_t     imm;
    logic      wb_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    xlen_t       regs [32];                     // Register state in program order.
    xlen_t       rf_visible [32];               // Register file contents, written at write-back.
    xlen_t       mem_model [mem_depth];
    logic [31:0] lfsr_state = 32'h3c61_7828;
    int          cycle = 0;                     // Falling edges seen so far.
    int          checks = 0;
    int          errors = 0;
    string       test_name;

    int        exp_due [$];                     // Falling edge at which each result is due.
    logic      exp_en [$];
    reg_addr_t exp_rd [$];
    xlen_t     exp_data [$];
    string     exp_test [$];

    alu_op_t alu_ops [10] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
                              alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu};

    rv64_backend rv64_backend_inst (
        .clk          (clk),
        .reset        (reset),
        .alu_op       (alu_op),
        .alu_src      (alu_src),
        .mem_to_reg   (mem_to_reg),
        .reg_write_en (reg_write_en),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .imm          (imm),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    always #10 clk = ~clk;

    // Galois LFSR stepped once for every bit taken.
    function automatic xlen_t random_bits(input int count);
        xlen_t value;
        logic  out_bit;
        int    i;
        value = '0;
        for (i = 0; i < count; i++) begin
            out_bit = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ lfsr_taps;
            end
            value = {value[xlen-2:0], out_bit};
        end
        return value;
    endfunction

    function automatic xlen_t model_alu(input alu_op_t op, input xlen_t a, input xlen_t b);
        int    sh;
        xlen_t ones;
        sh   = int'(b[5:0]);
        ones = '1;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | (a[xlen-1] ? ~(ones >> sh) : '0);    // Sign fill.
            alu_slt:  return xlen_t'((a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b));
            alu_sltu: return xlen_t'(a < b);
            default:  return '0;
        endcase
    endfunction

    // Drives one instruction and queues the write-back it must produce two cycles later.
    task automatic issue(
        input alu_op_t   op,
        input logic      use_imm,
        input reg_addr_t src1,
        input reg_addr_t src2,
        input reg_addr_t dest,
        input xlen_t     imm_value,
        input logic      writes_reg,
        input logic      is_load,
        input logic      is_store
    );
        xlen_t      result;
        xlen_t      wb_value;
        mem_index_t index;
        @(posedge clk);
        result   = model_alu(op, regs[src1], use_imm ? imm_value : regs[src2]);
        index    = result[mem_index_msb:mem_index_lsb];
        wb_value = is_load ? mem_model[index] : result;
        alu_op       <= op;
        alu_src      <= use_imm;
        mem_to_reg   <= is_load;
        reg_write_en <= writes_reg;
        mem_read     <= is_load;
        mem_write    <= is_store;
        rs1          <= src1;
        rs2          <= src2;
        rd           <= dest;
        rs1_value    <= rf_visible[src1];       // Stale while the producer is still in flight.
        rs2_value    <= rf_visible[src2];
        imm          <= imm_value;
        if (is_store) begin
            mem_model[index] = regs[src2];
        end
        if (writes_reg && dest != '0) begin
            regs[dest] = wb_value;
        end
        exp_due.push_back(cycle + 3);           // The falling edge after the second rising edge.
        exp_en.push_back(writes_reg);
        exp_rd.push_back(dest);
        exp_data.push_back(wb_value);
        exp_test.push_back(test_name);
    endtask

    task automatic issue_alu(input alu_op_t op, input reg_addr_t src1, input reg_addr_t src2,
                             input reg_addr_t dest);
        issue(op, 1'b0, src1, src2, dest, '0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic issue_alu_imm(input alu_op_t op, input reg_addr_t src1,
                                 input reg_addr_t dest, input xlen_t imm_value);
        issue(op, 1'b1, src1, 5'd0, dest, imm_value, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic issue_load(input reg_addr_t dest, input reg_addr_t base, input xlen_t offset);
        issue(alu_add, 1'b1, base, 5'd0, dest, offset, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic issue_store(input reg_addr_t src, input reg_addr_t base, input xlen_t offset);
        issue(alu_add, 1'b1, base, src, 5'd0, offset, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic issue_bubble();
        issue(alu_add, 1'b0, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic check_writeback();
        checks++;
        assert (wb_en === exp_en[0]) else begin
            $display("FAILED wb_en: expected %h, got %h (%s)", exp_en[0], wb_en, exp_test[0]);
            errors++;
        end
        assert (wb_rd === exp_rd[0]) else begin
            $display("FAILED wb_rd: expected %h, got %h (%s)", exp_rd[0], wb_rd, exp_test[0]);
            errors++;
        end
        assert (wb_data === exp_data[0]) else begin
            $display("FAILED wb_data: expected %h, got %h (%s)", exp_data[0], wb_data,
                     exp_test[0]);
            errors++;
        end
        if (exp_en[0] && exp_rd[0] != '0) begin
            rf_visible[exp_rd[0]] = exp_data[0];
        end
        exp_due.delete(0);
        exp_en.delete(0);
        exp_rd.delete(0);
        exp_data.delete(0);
        exp_test.delete(0);
    endtask

    // Outputs are compared half a cycle after the edge that updates them.
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (exp_due.size() > 0 && exp_due[0] == cycle) begin
            check_writeback();
        end
    end

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_due.size() > 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_due.size() > 0) begin
            $display("Timed out with %0d write-back results never checked", exp_due.size());
            errors++;
        end
    endtask

    task automatic test_reset_bubbles();
        test_name = "reset bubbles";
        repeat (4) issue_bubble();
    endtask

    task automatic test_alu_ops();
        int round;
        int k;
        test_name = "ALU operations";
        for (round = 0; round < 2; round++) begin
            for (k = 1; k <= 3; k++) begin
                issue_alu_imm(alu_add, 5'd0, reg_addr_t'(k), random_bits(xlen));
            end
            issue_bubble();
            issue_bubble();                     // Sources are written back before use.
            for (k = 0; k < 10; k++) begin
                issue_alu(alu_ops[k], 5'd1, 5'd2, reg_addr_t'(10 + k));
                issue_alu_imm(alu_ops[k], 5'd3, reg_addr_t'(20 + k), random_bits(xlen));
            end
        end
        issue_bubble();
        issue_bubble();
    endtask

    task automatic test_ex_mem_forwarding();
        test_name = "EX/MEM forwarding";
        issue_alu_imm(alu_add, 5'd0, 5'd5, random_bits(xlen));
        issue_alu(alu_add, 5'd5, 5'd2, 5'd6);              // Operand a.
        issue_alu(alu_sub, 5'd1, 5'd6, 5'd7);              // Operand b.
        issue_alu(alu_add, 5'd7, 5'd7, 5'd8);
        issue_alu_imm(alu_sra, 5'd8, 5'd9, random_bits(6));
        issue_bubble();
        issue_bubble();
    endtask

    task automatic test_mem_wb_forwarding();
        test_name = "MEM/WB forwarding";
        issue_alu_imm(alu_add, 5'd0, 5'd11, random_bits(xlen));
        issue_bubble();
        issue_alu(alu_or, 5'd11, 5'd1, 5'd12);
        issue_alu_imm(alu_add, 5'd0, 5'd13, random_bits(xlen));
        issue_bubble();
        issue_alu(alu_sub, 5'd2, 5'd13, 5'd14);
        issue_alu_imm(alu_add, 5'd0, 5'd15, random_bits(xlen));
        issue_alu_imm(alu_xor, 5'd0, 5'd15, random_bits(xlen));
        issue_alu(alu_add, 5'd15, 5'd15, 5'd16);           // The newer x15 must win.
        issue_alu_imm(alu_add, 5'd0, 5'd0, random_bits(xlen));
        issue_alu(alu_add, 5'd0, 5'd1, 5'd17);
        issue_alu(alu_or, 5'd2, 5'd0, 5'd18);              // x0 still reads zero.
        issue_bubble();
        issue_bubble();
    endtask

    task automatic test_load_store();
        test_name = "load and store";
        issue_alu_imm(alu_add, 5'd0, 5'd20, 64'h0000_0000_0000_0200);
        issue_alu_imm(alu_add, 5'd0, 5'd21, random_bits(xlen));
        issue_store(5'd21, 5'd20, 64'd8);
        issue_load(5'd22, 5'd20, 64'd8);                   // Sees the store just before it.
        issue_store(5'd22, 5'd20, 64'd16);                 // Data comes from write-back.
        issue_bubble();
        issue_bubble();
        issue_load(5'd24, 5'd20, 64'd16);
        issue_bubble();
        issue_alu(alu_add, 5'd24, 5'd1, 5'd25);
        issue_load(5'd26, 5'd20, 64'h0000_0001_0000_0008); // Upper address bits are ignored.
        issue_bubble();
        issue_bubble();
    endtask

    initial begin
        int i;
        reset        <= 1'b1;
        alu_op       <= alu_add;
        alu_src      <= 1'b0;
        mem_to_reg   <= 1'b0;
        reg_write_en <= 1'b0;
        mem_read     <= 1'b0;
        mem_write    <= 1'b0;
        rs1          <= '0;
        rs2          <= '0;
        rd           <= '0;
        rs1_value    <= '0;
        rs2_value    <= '0;
        imm          <= '0;
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
            rf_visible[i] = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_reset_bubbles();
        test_alu_ops();
        test_ex_mem_forwarding();
        test_mem_wb_forwarding();
        test_load_store();
        wait_for_drain();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
